//--- src/ram_pkg.sv
package ram_pkg;

    // Size code 3 is illegal
    typedef enum logic [1:0] {
        SIZE_BYTE  = 2'd0,
        SIZE_WORD  = 2'd1,
        SIZE_DWORD = 2'd2
    } access_size_e;

    localparam int BYTE_W     = 8;
    localparam int DWORD_W    = 64;
    localparam int LANES      = 8;
    localparam int ADDR_BUS_W = 64;

    typedef logic [DWORD_W-1:0] dword_t;

    // One enable bit per byte lane
    typedef logic [LANES-1:0] lane_mask_t;

    // Lane 0 of a row holds the lowest address
    typedef logic [LANES-1:0][BYTE_W-1:0] row_t;

    // Configuration bytes at the bottom of the address space
    localparam int RESERVED_COUNT = 4;

    typedef logic [RESERVED_COUNT-1:0][BYTE_W-1:0] reserved_t;

    // Index 0 is address 0x0
    localparam reserved_t RESERVED_DEFAULT = {
        8'h8F,
        8'h23,
        8'h23,
        8'h00
    };

    // One decoded access
    typedef struct packed {
        logic         valid;
        logic         fault;
        access_size_e size;
        logic [2:0]   offset;
        logic [15:0]  row;
    } mem_req_t;

endpackage

//--- src/access_decode.sv
`timescale 1ns/1ns

module access_decode
    import ram_pkg::*;
#(
    parameter int DEPTH = 256
) (
    input  logic [ADDR_BUS_W-1:0] addr_i,
    input  access_size_e          size_i,
    input  logic                  en_i,
    output mem_req_t              req_o
);

    localparam int ADDR_W = $clog2(DEPTH);
    localparam int ROW_W  = ADDR_W - 3;

    logic misaligned;

    // Code 3 never passes the alignment check
    always_comb begin
        case (size_i)
            SIZE_BYTE: begin
                misaligned = 1'b0;
            end
            SIZE_WORD: begin
                misaligned = (addr_i[1:0] != 2'b00);
            end
            SIZE_DWORD: begin
                misaligned = (addr_i[2:0] != 3'b000);
            end
            default: begin
                misaligned = 1'b1;
            end
        endcase
    end

    always_comb begin
        req_o        = '0;
        req_o.valid  = en_i;
        // Fault only on an enabled access
        req_o.fault  = en_i & misaligned;
        req_o.size   = size_i;
        req_o.offset = addr_i[2:0];
        // Upper address bits beyond the depth are ignored
        req_o.row[ROW_W-1:0] = addr_i[ADDR_W-1:3];
    end

endmodule

//--- src/write_stage.sv
`timescale 1ns/1ns

module write_stage
    import ram_pkg::*;
#(
    parameter int DEPTH = 256,
    localparam int ROW_W = $clog2(DEPTH) - 3
) (
    input  logic             clk,
    input  logic             rst_n,
    input  mem_req_t         req_i,
    input  dword_t           data_i,
    output logic             busy_o,
    output logic             fault_o,
    output logic             commit_o,
    output logic [ROW_W-1:0] row_o,
    output lane_mask_t       mask_o,
    output dword_t           data_o
);

    typedef enum logic {
        ST_IDLE,
        ST_COMMIT
    } state_e;

    state_e     state;
    mem_req_t   req_q;
    dword_t     data_q;
    lane_mask_t mask_base;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            req_q    <= '0;
            commit_o <= 1'b0;
        end else begin
            commit_o <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req_i.valid) begin
                        state <= ST_COMMIT;
                        req_q <= req_i;
                    end
                end
                default: begin
                    // Faulty requests leave the array untouched
                    commit_o <= req_q.valid & ~req_q.fault;
                    state    <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req_i.valid) begin
            data_q <= data_i;
        end
    end

    always_comb begin
        case (req_q.size)
            SIZE_BYTE:  mask_base = 8'h01;
            SIZE_WORD:  mask_base = 8'h0F;
            SIZE_DWORD: mask_base = 8'hFF;
            default:    mask_base = 8'h00;
        endcase
    end

    // Move the lowest data byte onto the addressed lane
    assign mask_o   = mask_base << req_q.offset;
    assign data_o   = data_q << {req_q.offset, 3'b000};
    assign row_o    = req_q.row[ROW_W-1:0];
    assign busy_o   = (state == ST_COMMIT);
    assign fault_o  = req_q.fault;

endmodule

//--- src/byte_array.sv
`timescale 1ns/1ns

module byte_array
    import ram_pkg::*;
#(
    parameter int DEPTH = 256,
    localparam int ROW_W = $clog2(DEPTH) - 3
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr_en_i,
    input  logic [ROW_W-1:0] wr_row_i,
    input  lane_mask_t       wr_mask_i,
    input  dword_t           wr_data_i,
    input  logic [ROW_W-1:0] rd_row_1_i,
    input  logic [ROW_W-1:0] rd_row_2_i,
    output dword_t           rd_data_1_o,
    output dword_t           rd_data_2_o,
    output reserved_t        reserved_o
);

    localparam int ROWS = DEPTH / LANES;

    row_t mem [ROWS];
    row_t wr_lanes;

    // Reset image of one row
    function automatic row_t reset_row(input int r);
        row_t v;
        int   idx;
        v = '0;
        for (int l = 0; l < LANES; l++) begin
            idx = r * LANES + l;
            if (idx < RESERVED_COUNT) begin
                v[l] = RESERVED_DEFAULT[idx];
            end
        end
        return v;
    endfunction

    assign wr_lanes = wr_data_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < ROWS; r++) begin
                mem[r] <= reset_row(r);
            end
        end else if (wr_en_i) begin
            // Only the enabled lanes of the row change
            for (int l = 0; l < LANES; l++) begin
                if (wr_mask_i[l]) begin
                    mem[wr_row_i][l] <= wr_lanes[l];
                end
            end
        end
    end

    // Two independent combinational row reads
    assign rd_data_1_o = mem[rd_row_1_i];
    assign rd_data_2_o = mem[rd_row_2_i];

    for (genvar i = 0; i < RESERVED_COUNT; i++) begin : g_reserved
        assign reserved_o[i] = mem[i / LANES][i % LANES];
    end

endmodule

//--- src/read_result.sv
`timescale 1ns/1ns

module read_result
    import ram_pkg::*;
(
    input  mem_req_t req_i,
    input  dword_t   row_i,
    output dword_t   data_o,
    output logic     fault_o
);

    dword_t shifted;

    // Bring the addressed byte down to lane 0
    assign shifted = row_i >> {req_i.offset, 3'b000};

    always_comb begin
        data_o = '0;
        if (req_i.valid && !req_i.fault) begin
            case (req_i.size)
                SIZE_BYTE: begin
                    data_o = DWORD_W'(shifted[BYTE_W-1:0]);
                end
                SIZE_WORD: begin
                    data_o = DWORD_W'(shifted[4*BYTE_W-1:0]);
                end
                SIZE_DWORD: begin
                    data_o = shifted;
                end
                default: begin
                    data_o = '0;
                end
            endcase
        end
    end

    // Decode keeps the fault low on a disabled port
    assign fault_o = req_i.fault;

endmodule

//--- src/data_ram.sv
`timescale 1ns/1ns

module data_ram
    import ram_pkg::*;
#(
    parameter int DEPTH = 256
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // Write port
    input  logic                  wr_ins_i,
    input  logic [ADDR_BUS_W-1:0] wr_addr_i,
    input  access_size_e          wr_size_i,
    input  dword_t                wr_data_i,
    output logic                  wr_busy_o,
    output logic                  invalid_wr_flag_o,
    // Read port 1
    input  logic                  rd_en_1_i,
    input  logic [ADDR_BUS_W-1:0] rd_addr_1_i,
    input  access_size_e          rd_size_1_i,
    output dword_t                rd_data_1_o,
    output logic                  invalid_rd_flag_1_o,
    // Read port 2
    input  logic                  rd_en_2_i,
    input  logic [ADDR_BUS_W-1:0] rd_addr_2_i,
    input  access_size_e          rd_size_2_i,
    output dword_t                rd_data_2_o,
    output logic                  invalid_rd_flag_2_o,
    output reserved_t             reserved_o
);

    localparam int ROW_W = $clog2(DEPTH) - 3;

    mem_req_t         wr_req;
    mem_req_t         rd_req_1;
    mem_req_t         rd_req_2;
    logic             commit;
    logic [ROW_W-1:0] commit_row;
    lane_mask_t       commit_mask;
    dword_t           commit_data;
    dword_t           row_data_1;
    dword_t           row_data_2;

    access_decode #(.DEPTH(DEPTH)) u_wr_decode (
        .addr_i (wr_addr_i),
        .size_i (wr_size_i),
        .en_i   (wr_ins_i),
        .req_o  (wr_req)
    );

    access_decode #(.DEPTH(DEPTH)) u_rd_decode_1 (
        .addr_i (rd_addr_1_i),
        .size_i (rd_size_1_i),
        .en_i   (rd_en_1_i),
        .req_o  (rd_req_1)
    );

    access_decode #(.DEPTH(DEPTH)) u_rd_decode_2 (
        .addr_i (rd_addr_2_i),
        .size_i (rd_size_2_i),
        .en_i   (rd_en_2_i),
        .req_o  (rd_req_2)
    );

    write_stage #(.DEPTH(DEPTH)) u_write_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_i    (wr_req),
        .data_i   (wr_data_i),
        .busy_o   (wr_busy_o),
        .fault_o  (invalid_wr_flag_o),
        .commit_o (commit),
        .row_o    (commit_row),
        .mask_o   (commit_mask),
        .data_o   (commit_data)
    );

    byte_array #(.DEPTH(DEPTH)) u_byte_array (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_en_i     (commit),
        .wr_row_i    (commit_row),
        .wr_mask_i   (commit_mask),
        .wr_data_i   (commit_data),
        .rd_row_1_i  (rd_req_1.row[ROW_W-1:0]),
        .rd_row_2_i  (rd_req_2.row[ROW_W-1:0]),
        .rd_data_1_o (row_data_1),
        .rd_data_2_o (row_data_2),
        .reserved_o  (reserved_o)
    );

    read_result u_read_result_1 (
        .req_i   (rd_req_1),
        .row_i   (row_data_1),
        .data_o  (rd_data_1_o),
        .fault_o (invalid_rd_flag_1_o)
    );

    read_result u_read_result_2 (
        .req_i   (rd_req_2),
        .row_i   (row_data_2),
        .data_o  (rd_data_2_o),
        .fault_o (invalid_rd_flag_2_o)
    );

endmodule

//--- verif/data_ram_assert.sv
`timescale 1ns/1ns

module data_ram_assert
    import ram_pkg::*;
(
    input logic   clk,
    input logic   rst_n,
    input logic   wr_busy_i,
    input logic   wr_flag_i,
    input logic   rd_en_1_i,
    input dword_t rd_data_1_i,
    input logic   rd_flag_1_i,
    input logic   rd_en_2_i,
    input dword_t rd_data_2_i,
    input logic   rd_flag_2_i
);

    // Commit state lasts one cycle
    busy_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) wr_busy_i |=> !wr_busy_i
    ) else $error("wr_busy_o high for two consecutive cycles");

    rd_1_disabled_quiet: assert property (
        @(posedge clk) disable iff (!rst_n) !rd_en_1_i |-> (rd_data_1_i == '0 && !rd_flag_1_i)
    ) else $error("disabled read port 1 shows data or a flag");

    rd_2_disabled_quiet: assert property (
        @(posedge clk) disable iff (!rst_n) !rd_en_2_i |-> (rd_data_2_i == '0 && !rd_flag_2_i)
    ) else $error("disabled read port 2 shows data or a flag");

    // First cycle out of reset
    idle_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> (!wr_busy_i && !wr_flag_i)
    ) else $error("write port not idle after reset release");

endmodule

bind data_ram data_ram_assert u_data_ram_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_busy_i   (wr_busy_o),
    .wr_flag_i   (invalid_wr_flag_o),
    .rd_en_1_i   (rd_en_1_i),
    .rd_data_1_i (rd_data_1_o),
    .rd_flag_1_i (invalid_rd_flag_1_o),
    .rd_en_2_i   (rd_en_2_i),
    .rd_data_2_i (rd_data_2_o),
    .rd_flag_2_i (invalid_rd_flag_2_o)
);

//--- verif/data_ram_tb.sv
`timescale 1ns/1ns

module data_ram_tb
    import ram_pkg::*;
();

    localparam int DEPTH      = 256;
    localparam int WAIT_LIMIT = 20;

    logic                  clk;
    logic                  rst_n;
    logic                  wr_ins_i;
    logic [ADDR_BUS_W-1:0] wr_addr_i;
    access_size_e          wr_size_i;
    dword_t                wr_data_i;
    logic                  wr_busy_o;
    logic                  invalid_wr_flag_o;
    logic                  rd_en_1_i;
    logic [ADDR_BUS_W-1:0] rd_addr_1_i;
    access_size_e          rd_size_1_i;
    dword_t                rd_data_1_o;
    logic                  invalid_rd_flag_1_o;
    logic                  rd_en_2_i;
    logic [ADDR_BUS_W-1:0] rd_addr_2_i;
    access_size_e          rd_size_2_i;
    dword_t                rd_data_2_o;
    logic                  invalid_rd_flag_2_o;
    reserved_t             reserved_o;

    // Reference image of the whole memory
    logic [7:0]  model_mem [DEPTH];
    logic [31:0] lcg_state;
    string       cur_test;
    int          pass_count;
    int          fail_count;
    int          test_fails;

    data_ram #(.DEPTH(DEPTH)) dut (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int byte_count(input access_size_e size);
        case (size)
            SIZE_BYTE:  return 1;
            SIZE_WORD:  return 4;
            SIZE_DWORD: return 8;
            default:    return 0;
        endcase
    endfunction

    function automatic access_size_e size_from(input logic [31:0] r);
        case (r % 3)
            0:       return SIZE_BYTE;
            1:       return SIZE_WORD;
            default: return SIZE_DWORD;
        endcase
    endfunction

    function automatic logic [ADDR_BUS_W-1:0] aligned(input logic [ADDR_BUS_W-1:0] addr,
                                                      input access_size_e size);
        return addr & ~ADDR_BUS_W'(byte_count(size) - 1);
    endfunction

    // Misaligned or illegal size on an enabled access
    function automatic logic fault_expected(input logic [ADDR_BUS_W-1:0] addr,
                                            input access_size_e size, input logic en);
        int n;
        n = byte_count(size);
        if (!en) return 1'b0;
        if (n == 0) return 1'b1;
        return (int'(addr[2:0]) % n) != 0;
    endfunction

    // Little-endian read, zero-extended
    function automatic dword_t model_read(input logic [ADDR_BUS_W-1:0] addr,
                                          input access_size_e size, input logic en);
        dword_t v;
        v = '0;
        if (en && !fault_expected(addr, size, en)) begin
            for (int i = 0; i < byte_count(size); i++) begin
                v[8*i +: 8] = model_mem[(addr[7:0] + i) % DEPTH];
            end
        end
        return v;
    endfunction

    function automatic void model_write(input logic [ADDR_BUS_W-1:0] addr,
                                        input access_size_e size, input dword_t data);
        if (!fault_expected(addr, size, 1'b1)) begin
            for (int i = 0; i < byte_count(size); i++) begin
                model_mem[(addr[7:0] + i) % DEPTH] = data[8*i +: 8];
            end
        end
    endfunction

    task automatic check_dword(input string what, input dword_t exp, input dword_t act);
        if (exp === act) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (exp === act) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("FAILED %s %s: expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic check_reserved(input string what, input reserved_t exp,
                                  input reserved_t act);
        if (exp === act) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test   = name;
        test_fails = fail_count;
    endtask

    task automatic end_test();
        if (fail_count == test_fails) begin
            $display("%s: passed", cur_test);
        end else begin
            $display("%s: %0d failed checks", cur_test, fail_count - test_fails);
        end
    endtask

    // Issue one write and return after the row update edge
    task automatic write_mem(input logic [ADDR_BUS_W-1:0] addr, input access_size_e size,
                             input dword_t data, input logic hold);
        int n;
        @(posedge clk);
        wr_ins_i  <= 1'b1;
        wr_addr_i <= addr;
        wr_size_i <= size;
        wr_data_i <= data;
        @(posedge clk);
        if (hold) begin
            // A second request kept on the port while busy
            wr_addr_i <= addr ^ 64'h8;
            wr_data_i <= ~data;
        end else begin
            wr_ins_i <= 1'b0;
        end
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!wr_busy_o && n < WAIT_LIMIT);
        if (!wr_busy_o) begin
            fail_count++;
            $display("%s: write port never became busy", cur_test);
        end
        check_flag("write flag", fault_expected(addr, size, 1'b1), invalid_wr_flag_o);
        n = 0;
        while (wr_busy_o && n < WAIT_LIMIT) begin
            @(posedge clk);
            wr_ins_i <= 1'b0;
            @(negedge clk);
            n++;
        end
        if (wr_busy_o) begin
            fail_count++;
            $display("%s: write port stayed busy too long", cur_test);
        end
        @(posedge clk);
        model_write(addr, size, data);
    endtask

    task automatic read_ports(input logic en1, input logic [ADDR_BUS_W-1:0] a1,
                              input access_size_e s1, input logic en2,
                              input logic [ADDR_BUS_W-1:0] a2, input access_size_e s2);
        @(posedge clk);
        rd_en_1_i   <= en1;
        rd_addr_1_i <= a1;
        rd_size_1_i <= s1;
        rd_en_2_i   <= en2;
        rd_addr_2_i <= a2;
        rd_size_2_i <= s2;
        @(negedge clk);
        check_dword("port 1 data", model_read(a1, s1, en1), rd_data_1_o);
        check_flag("port 1 flag", fault_expected(a1, s1, en1), invalid_rd_flag_1_o);
        check_dword("port 2 data", model_read(a2, s2, en2), rd_data_2_o);
        check_flag("port 2 flag", fault_expected(a2, s2, en2), invalid_rd_flag_2_o);
    endtask

    task automatic test_reset_values();
        begin_test("reset_values");
        check_reserved("reserved bytes", {8'h8F, 8'h23, 8'h23, 8'h00}, reserved_o);
        for (int a = 0; a < RESERVED_COUNT; a++) begin
            read_ports(1'b1, ADDR_BUS_W'(a), SIZE_BYTE, 1'b1, ADDR_BUS_W'(a), SIZE_BYTE);
        end
        read_ports(1'b1, 64'd32, SIZE_DWORD, 1'b1, 64'd32, SIZE_DWORD);
        check_dword("row 4", 64'd0, rd_data_1_o);
        end_test();
    endtask

    task automatic test_aligned_access();
        logic [ADDR_BUS_W-1:0] addr;
        access_size_e          size;
        begin_test("aligned_access");
        for (int k = 0; k < 12; k++) begin
            size = size_from(k);
            addr = aligned(ADDR_BUS_W'(lcg_next() % DEPTH), size);
            write_mem(addr, size, {lcg_next(), lcg_next()}, 1'b0);
            read_ports(1'b1, addr, SIZE_BYTE, 1'b1, addr, SIZE_BYTE);
            read_ports(1'b1, aligned(addr, SIZE_WORD), SIZE_WORD,
                       1'b1, aligned(addr, SIZE_WORD), SIZE_WORD);
            read_ports(1'b1, aligned(addr, SIZE_DWORD), SIZE_DWORD,
                       1'b1, aligned(addr, SIZE_DWORD), SIZE_DWORD);
        end
        end_test();
    endtask

    task automatic test_byte_assembly();
        dword_t exp;
        dword_t data;
        begin_test("byte_assembly");
        exp = '0;
        for (int i = 0; i < LANES; i++) begin
            // Upper data bytes must not leak into other lanes
            data = {lcg_next(), lcg_next()};
            exp[8*i +: 8] = data[7:0];
            write_mem(64'h40 + ADDR_BUS_W'(i), SIZE_BYTE, data, 1'b0);
        end
        read_ports(1'b1, 64'h40, SIZE_DWORD, 1'b1, 64'h40, SIZE_DWORD);
        check_dword("assembled row", exp, rd_data_1_o);
        data = {lcg_next(), lcg_next()};
        write_mem(64'h44, SIZE_WORD, data, 1'b0);
        exp[63:32] = data[31:0];
        read_ports(1'b1, 64'h40, SIZE_DWORD, 1'b1, 64'h40, SIZE_DWORD);
        check_dword("upper half", exp, rd_data_2_o);
        end_test();
    endtask

    task automatic test_faults();
        dword_t data;
        begin_test("faults");
        data = {lcg_next(), lcg_next()};
        write_mem(64'h51, SIZE_WORD, data, 1'b0);
        write_mem(64'h54, SIZE_DWORD, data, 1'b0);
        write_mem(64'h60, access_size_e'(2'd3), data, 1'b0);
        read_ports(1'b1, 64'h50, SIZE_DWORD, 1'b1, 64'h60, SIZE_DWORD);
        read_ports(1'b1, 64'h02, SIZE_WORD, 1'b1, 64'h04, SIZE_DWORD);
        read_ports(1'b1, 64'h08, access_size_e'(2'd3), 1'b1, 64'h13, SIZE_DWORD);
        write_mem(64'h70, SIZE_WORD, data, 1'b0);
        check_flag("flag after good write", 1'b0, invalid_wr_flag_o);
        end_test();
    endtask

    task automatic test_disabled_and_held();
        dword_t data;
        begin_test("disabled_and_held");
        read_ports(1'b0, 64'h01, SIZE_BYTE, 1'b1, 64'h01, SIZE_BYTE);
        read_ports(1'b1, 64'h03, SIZE_WORD, 1'b0, 64'h03, SIZE_WORD);
        data = {lcg_next(), lcg_next()};
        write_mem(64'h80, SIZE_DWORD, data, 1'b1);
        read_ports(1'b1, 64'h80, SIZE_DWORD, 1'b1, 64'h88, SIZE_DWORD);
        check_dword("first request", data, rd_data_1_o);
        end_test();
    endtask

    task automatic test_random_mix();
        logic [31:0]           r;
        logic [ADDR_BUS_W-1:0] addr;
        logic [ADDR_BUS_W-1:0] addr2;
        access_size_e          size;
        access_size_e          size2;
        begin_test("random_mix");
        for (int i = 0; i < 40; i++) begin
            r     = lcg_next();
            size  = size_from(r >> 4);
            size2 = size_from(r >> 12);
            // Upper address bits are random and must be ignored
            addr  = aligned({lcg_next(), lcg_next()}, size);
            addr2 = aligned({lcg_next(), lcg_next()}, size2);
            if (r[0]) begin
                write_mem(addr, size, {lcg_next(), lcg_next()}, 1'b0);
            end else begin
                read_ports(1'b1, addr, size, 1'b1, addr2, size2);
            end
        end
        end_test();
    endtask

    initial begin
        lcg_state   = 32'he7f3;
        pass_count  = 0;
        fail_count  = 0;
        rst_n       = 1'b0;
        wr_ins_i    = 1'b0;
        wr_addr_i   = '0;
        wr_size_i   = SIZE_BYTE;
        wr_data_i   = '0;
        rd_en_1_i   = 1'b0;
        rd_addr_1_i = '0;
        rd_size_1_i = SIZE_BYTE;
        rd_en_2_i   = 1'b0;
        rd_addr_2_i = '0;
        rd_size_2_i = SIZE_BYTE;
        for (int i = 0; i < DEPTH; i++) begin
            model_mem[i] = 8'h00;
        end
        model_mem[1] = 8'h23;
        model_mem[2] = 8'h23;
        model_mem[3] = 8'h8F;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        test_reset_values();
        test_aligned_access();
        test_byte_assembly();
        test_faults();
        test_disabled_and_held();
        test_random_mix();
        $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
src/ram_pkg.sv
src/access_decode.sv
src/write_stage.sv
src/byte_array.sv
src/read_result.sv
src/data_ram.sv
verif/data_ram_assert.sv
verif/data_ram_tb.sv
